// File: logic/conv_types_pkg.sv
`default_nettype none

package conv_types_pkg;

    // Sample and accumulator formats.
    typedef logic signed [15:0] data_t;   // Pixel, weight and output sample.
    typedef logic signed [43:0] acc_t;    // 1024 channels x 3 taps of 16x16 products.

    // Job shape and output scaling.
    typedef logic [9:0] cols_t;
    typedef logic [9:0] cin_t;
    typedef logic [4:0] shift_t;

    // Saturation limits of a sample.
    localparam data_t data_max = 16'sh7fff;
    localparam data_t data_min = 16'sh8000;

endpackage

`default_nettype wire

// File: logic/conv_axil_pkg.sv
`default_nettype none

package conv_axil_pkg;

    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    // Register offsets.
    localparam axil_addr_t reg_ctrl   = 4'h0;
    localparam axil_addr_t reg_shape  = 4'h4;
    localparam axil_addr_t reg_shift  = 4'h8;
    localparam axil_addr_t reg_status = 4'hc;

    // Field positions.
    localparam int ctrl_start_bit  = 0;   // Write-one, reads as zero.
    localparam int ctrl_max_bit    = 1;
    localparam int ctrl_relu_bit   = 2;
    localparam int shape_cols_lsb  = 0;
    localparam int shape_cin_lsb   = 16;
    localparam int status_busy_bit = 0;

    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: logic/conv_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module conv_cfg_regs (
    input  wire                        aclk,
    input  wire                        rst_n,
    input  conv_axil_pkg::axil_addr_t  awaddr,
    input  wire                        awvalid,
    output logic                       awready,
    input  conv_axil_pkg::axil_data_t  wdata,
    input  conv_axil_pkg::axil_strb_t  wstrb,
    input  wire                        wvalid,
    output logic                       wready,
    output conv_axil_pkg::axil_resp_t  bresp,
    output logic                       bvalid,
    input  wire                        bready,
    input  conv_axil_pkg::axil_addr_t  araddr,
    input  wire                        arvalid,
    output logic                       arready,
    output conv_axil_pkg::axil_data_t  rdata,
    output conv_axil_pkg::axil_resp_t  rresp,
    output logic                       rvalid,
    input  wire                        rready,
    input  wire                        busy_done,
    output logic                       start,
    output logic                       busy,
    output logic                       is_max,
    output logic                       is_relu,
    output conv_types_pkg::cols_t      cols_1,
    output conv_types_pkg::cin_t       cin_1,
    output conv_types_pkg::shift_t     shift
);

    conv_axil_pkg::axil_data_t ctrl_img, shape_img, shift_img, status_img;
    conv_axil_pkg::axil_data_t ctrl_new, shape_new, shift_new;
    logic wr_en;
    logic rd_en;

    function automatic conv_axil_pkg::axil_data_t merge_strb(
        input conv_axil_pkg::axil_data_t old_v,
        input conv_axil_pkg::axil_data_t new_v,
        input conv_axil_pkg::axil_strb_t strb
    );
        conv_axil_pkg::axil_data_t res;
        res = old_v;
        for (int b = 0; b < $bits(strb); b++) begin
            if (strb[b])
                res[8*b +: 8] = new_v[8*b +: 8];
        end
        return res;
    endfunction

    // Current register contents as the bus sees them.
    always_comb begin
        ctrl_img   = '0;
        ctrl_img[conv_axil_pkg::ctrl_max_bit]  = is_max;
        ctrl_img[conv_axil_pkg::ctrl_relu_bit] = is_relu;
        shape_img  = '0;
        shape_img[conv_axil_pkg::shape_cols_lsb +: $bits(cols_1)] = cols_1;
        shape_img[conv_axil_pkg::shape_cin_lsb  +: $bits(cin_1)]  = cin_1;
        shift_img  = '0;
        shift_img[$bits(shift)-1:0] = shift;
        status_img = '0;
        status_img[conv_axil_pkg::status_busy_bit] = busy;
        ctrl_new   = merge_strb(ctrl_img,  wdata, wstrb);
        shape_new  = merge_strb(shape_img, wdata, wstrb);
        shift_new  = merge_strb(shift_img, wdata, wstrb);
    end

    assign wr_en = awvalid && awready && wvalid && wready;
    assign rd_en = arvalid && arready;

    // ************************************************************
    // Write channel and job control.
    // ************************************************************
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= conv_axil_pkg::resp_okay;
            start   <= 1'b0;
            busy    <= 1'b0;
            is_max  <= 1'b0;
            is_relu <= 1'b0;
            cols_1  <= '0;
            cin_1   <= '0;
            shift   <= '0;
        end else begin
            start   <= 1'b0;
            awready <= awvalid && wvalid && !awready && !bvalid;   // One-cycle accept.
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (busy_done)
                busy <= 1'b0;
            if (wr_en) begin
                bvalid <= 1'b1;
                bresp  <= conv_axil_pkg::resp_okay;
                case (awaddr)
                    conv_axil_pkg::reg_ctrl: begin
                        if (!busy) begin
                            is_max  <= ctrl_new[conv_axil_pkg::ctrl_max_bit];
                            is_relu <= ctrl_new[conv_axil_pkg::ctrl_relu_bit];
                            start   <= ctrl_new[conv_axil_pkg::ctrl_start_bit];
                            busy    <= ctrl_new[conv_axil_pkg::ctrl_start_bit];
                        end
                    end
                    conv_axil_pkg::reg_shape: begin
                        if (!busy) begin
                            cols_1 <= shape_new[conv_axil_pkg::shape_cols_lsb +: $bits(cols_1)];
                            cin_1  <= shape_new[conv_axil_pkg::shape_cin_lsb  +: $bits(cin_1)];
                        end
                    end
                    conv_axil_pkg::reg_shift: begin
                        if (!busy)
                            shift <= shift_new[$bits(shift)-1:0];
                    end
                    default: bresp <= conv_axil_pkg::resp_slverr;   // STATUS and holes.
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Read channel.
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= conv_axil_pkg::resp_okay;
            rdata   <= '0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_en) begin
                rvalid <= 1'b1;
                rresp  <= conv_axil_pkg::resp_okay;
                case (araddr)
                    conv_axil_pkg::reg_ctrl:   rdata <= ctrl_img;
                    conv_axil_pkg::reg_shape:  rdata <= shape_img;
                    conv_axil_pkg::reg_shift:  rdata <= shift_img;
                    conv_axil_pkg::reg_status: rdata <= status_img;
                    default: begin
                        rdata <= '0;
                        rresp <= conv_axil_pkg::resp_slverr;
                    end
                endcase
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/conv_tap_mac.sv
`timescale 1ns/10ps
`default_nettype none

module conv_tap_mac #(
    parameter int CONV_UNITS = 8,
    parameter int KERNEL_H   = 3
) (
    input  wire                                                   aclk,
    input  wire                                                   rst_n,
    input  wire                                                   start,
    input  wire                                                   busy,
    input  wire                                                   is_max,
    input  conv_types_pkg::cols_t                                 cols_1,
    input  conv_types_pkg::cin_t                                  cin_1,
    input  wire                                                   s_pixels_valid,
    input  wire [(CONV_UNITS+KERNEL_H-1)*$bits(conv_types_pkg::data_t)-1:0] s_pixels_data,
    output logic                                                  s_pixels_ready,
    input  wire                                                   s_weights_valid,
    input  wire [KERNEL_H*$bits(conv_types_pkg::data_t)-1:0]      s_weights_data,
    output logic                                                  s_weights_ready,
    output logic                                                  acc_valid,
    output logic [CONV_UNITS*$bits(conv_types_pkg::acc_t)-1:0]    acc_data,
    output logic                                                  acc_last,
    input  wire                                                   acc_ready
);

    localparam int DW    = $bits(conv_types_pkg::data_t);
    localparam int AW    = $bits(conv_types_pkg::acc_t);
    localparam int PIX_N = CONV_UNITS + KERNEL_H - 1;

    typedef enum logic [1:0] {st_idle, st_run, st_hold} state_t;

    state_t                 state;
    conv_types_pkg::cin_t   cin_cnt;
    conv_types_pkg::cols_t  col_cnt;
    conv_types_pkg::data_t  pix [PIX_N];
    conv_types_pkg::data_t  wgt [KERNEL_H];
    conv_types_pkg::acc_t   acc [CONV_UNITS];
    conv_types_pkg::acc_t   tap_sum [CONV_UNITS];
    conv_types_pkg::data_t  tap_max [CONV_UNITS];
    logic                   in_ready;
    logic                   beat;
    logic                   col_end;

    // Both streams are taken together in conv mode, pixels alone in max mode.
    assign in_ready        = (state == st_run) && busy &&
                             (is_max || (s_pixels_valid && s_weights_valid));
    assign s_pixels_ready  = in_ready;
    assign s_weights_ready = in_ready && !is_max;
    assign beat            = s_pixels_valid && in_ready;
    assign col_end         = (cin_cnt == cin_1);
    assign acc_valid       = (state == st_hold);

    // ************************************************************
    // Per-unit taps.
    // ************************************************************
    always_comb begin
        for (int i = 0; i < PIX_N; i++)
            pix[i] = s_pixels_data[i*DW +: DW];
        for (int k = 0; k < KERNEL_H; k++)
            wgt[k] = s_weights_data[k*DW +: DW];
        for (int u = 0; u < CONV_UNITS; u++) begin
            tap_sum[u] = '0;
            tap_max[u] = pix[u];
            for (int k = 0; k < KERNEL_H; k++) begin
                tap_sum[u] = tap_sum[u] + pix[u+k] * wgt[k];
                if (pix[u+k] > tap_max[u])
                    tap_max[u] = pix[u+k];
            end
            acc_data[u*AW +: AW] = acc[u];
        end
    end

    // First beat of a column starts the accumulator afresh.
    always_ff @(posedge aclk) begin
        if (beat) begin
            for (int u = 0; u < CONV_UNITS; u++) begin
                if (is_max) begin
                    if (cin_cnt == '0 || conv_types_pkg::acc_t'(tap_max[u]) > acc[u])
                        acc[u] <= conv_types_pkg::acc_t'(tap_max[u]);
                end else if (cin_cnt == '0) begin
                    acc[u] <= tap_sum[u];
                end else begin
                    acc[u] <= acc[u] + tap_sum[u];
                end
            end
        end
    end

    // ************************************************************
    // Counters and FSM.
    // ************************************************************
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state    <= st_idle;
            cin_cnt  <= '0;
            col_cnt  <= '0;
            acc_last <= 1'b0;
        end else if (start) begin
            state    <= st_run;
            cin_cnt  <= '0;
            col_cnt  <= '0;
            acc_last <= 1'b0;
        end else begin
            case (state)
                st_run: begin
                    if (beat) begin
                        cin_cnt <= col_end ? '0 : cin_cnt + 1'b1;
                        if (col_end) begin
                            state    <= st_hold;
                            acc_last <= (col_cnt == cols_1);
                            col_cnt  <= col_cnt + 1'b1;
                        end
                    end
                end
                st_hold: begin
                    if (acc_ready)
                        state <= acc_last ? st_idle : st_run;   // Job ends after last column.
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/conv_result_stage.sv
`timescale 1ns/10ps
`default_nettype none

module conv_result_stage #(
    parameter int CONV_UNITS = 8
) (
    input  wire                                                aclk,
    input  wire                                                rst_n,
    input  wire                                                is_relu,
    input  conv_types_pkg::shift_t                             shift,
    input  wire                                                acc_valid,
    input  wire [CONV_UNITS*$bits(conv_types_pkg::acc_t)-1:0]  acc_data,
    input  wire                                                acc_last,
    output logic                                               acc_ready,
    output logic                                               m_valid,
    output logic [CONV_UNITS*$bits(conv_types_pkg::data_t)-1:0] m_data,
    output logic                                               m_last,
    input  wire                                                m_ready,
    output logic                                               busy_done
);

    localparam int DW = $bits(conv_types_pkg::data_t);
    localparam int AW = $bits(conv_types_pkg::acc_t);

    logic [CONV_UNITS*DW-1:0] res_data;

    // Shift, then ReLU, then clip to the sample range.
    function automatic conv_types_pkg::data_t scale(
        input conv_types_pkg::acc_t   a,
        input conv_types_pkg::shift_t sh,
        input logic                   relu
    );
        conv_types_pkg::acc_t v;
        v = a >>> sh;
        if (relu && v < 0)
            v = '0;
        if (v > conv_types_pkg::acc_t'(conv_types_pkg::data_max))
            return conv_types_pkg::data_max;
        if (v < conv_types_pkg::acc_t'(conv_types_pkg::data_min))
            return conv_types_pkg::data_min;
        return conv_types_pkg::data_t'(v);
    endfunction

    always_comb begin
        for (int u = 0; u < CONV_UNITS; u++)
            res_data[u*DW +: DW] = scale(acc_data[u*AW +: AW], shift, is_relu);
    end

    assign acc_ready = !m_valid || m_ready;            // Empty or draining.
    assign busy_done = m_valid && m_ready && m_last;

    // ************************************************************
    // Output register.
    // ************************************************************
    always_ff @(posedge aclk) begin
        if (!rst_n)
            m_valid <= 1'b0;
        else if (acc_valid && acc_ready)
            m_valid <= 1'b1;
        else if (m_ready)
            m_valid <= 1'b0;
    end

    always_ff @(posedge aclk) begin
        if (acc_valid && acc_ready) begin
            m_data <= res_data;
            m_last <= acc_last;
        end
    end

endmodule

`default_nettype wire

// File: logic/conv_engine_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_engine_top #(
    parameter int CONV_UNITS = 8,
    parameter int KERNEL_H   = 3
) (
    input  wire                                                   aclk,
    input  wire                                                   rst_n,
    input  conv_axil_pkg::axil_addr_t                             awaddr,
    input  wire                                                   awvalid,
    output logic                                                  awready,
    input  conv_axil_pkg::axil_data_t                             wdata,
    input  conv_axil_pkg::axil_strb_t                             wstrb,
    input  wire                                                   wvalid,
    output logic                                                  wready,
    output conv_axil_pkg::axil_resp_t                             bresp,
    output logic                                                  bvalid,
    input  wire                                                   bready,
    input  conv_axil_pkg::axil_addr_t                             araddr,
    input  wire                                                   arvalid,
    output logic                                                  arready,
    output conv_axil_pkg::axil_data_t                             rdata,
    output conv_axil_pkg::axil_resp_t                             rresp,
    output logic                                                  rvalid,
    input  wire                                                   rready,
    input  wire                                                   s_pixels_valid,
    input  wire [(CONV_UNITS+KERNEL_H-1)*$bits(conv_types_pkg::data_t)-1:0] s_pixels_data,
    output logic                                                  s_pixels_ready,
    input  wire                                                   s_weights_valid,
    input  wire [KERNEL_H*$bits(conv_types_pkg::data_t)-1:0]      s_weights_data,
    output logic                                                  s_weights_ready,
    output logic                                                  m_valid,
    output logic [CONV_UNITS*$bits(conv_types_pkg::data_t)-1:0]   m_data,
    output logic                                                  m_last,
    input  wire                                                   m_ready
);

    logic                   start, busy, busy_done;
    logic                   is_max, is_relu;
    conv_types_pkg::cols_t  cols_1;
    conv_types_pkg::cin_t   cin_1;
    conv_types_pkg::shift_t shift;
    logic                   acc_valid, acc_ready, acc_last;
    logic [CONV_UNITS*$bits(conv_types_pkg::acc_t)-1:0] acc_data;

    conv_cfg_regs i_regs (
        .aclk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .busy_done, .start, .busy, .is_max, .is_relu, .cols_1, .cin_1, .shift
    );

    conv_tap_mac #(
        .CONV_UNITS (CONV_UNITS),
        .KERNEL_H   (KERNEL_H)
    ) i_mac (
        .aclk, .rst_n, .start, .busy, .is_max, .cols_1, .cin_1,
        .s_pixels_valid, .s_pixels_data, .s_pixels_ready,
        .s_weights_valid, .s_weights_data, .s_weights_ready,
        .acc_valid, .acc_data, .acc_last, .acc_ready
    );

    conv_result_stage #(
        .CONV_UNITS (CONV_UNITS)
    ) i_result (
        .aclk, .rst_n, .is_relu, .shift,
        .acc_valid, .acc_data, .acc_last, .acc_ready,
        .m_valid, .m_data, .m_last, .m_ready, .busy_done
    );

endmodule

`default_nettype wire

// File: verif/conv_engine_model.svh
`ifndef CONV_ENGINE_MODEL_SVH
`define CONV_ENGINE_MODEL_SVH

// Fibonacci LFSR with taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(inout logic [31:0] st, input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        st = lfsr_step(st);
        r  = {r[30:0], st[0]};   // One step per bit.
    end
    return r;
endfunction

// Signed value of vbits random bits, widened to a sample.
function automatic logic [DW-1:0] rand_sample(inout logic [31:0] st, input int vbits);
    logic signed [31:0] s;
    s = rand_bits(st, vbits) << (32 - vbits);
    s = s >>> (32 - vbits);
    return s[DW-1:0];
endfunction

function automatic longint sample_at(input logic [PIX_W-1:0] beat, input int n);
    return longint'($signed(beat[n*DW +: DW]));
endfunction

// Contribution of one beat to unit u.
function automatic longint unit_term(input logic [PIX_W-1:0] p, input logic [WGT_W-1:0] w,
                                     input int u, input bit max_mode);
    longint t;
    t = max_mode ? sample_at(p, u) : 0;
    for (int k = 0; k < TAPS; k++) begin
        if (!max_mode)
            t = t + sample_at(p, u + k) * longint'($signed(w[k*DW +: DW]));
        else if (sample_at(p, u + k) > t)
            t = sample_at(p, u + k);
    end
    return t;
endfunction

// Arithmetic shift, then ReLU, then clip to the sample range.
function automatic logic [DW-1:0] out_sample(input longint a, input int sh, input bit relu);
    longint v;
    v = a >>> sh;
    if (relu && v < 0)
        v = 0;
    if (v > 32767)
        v = 32767;
    else if (v < -32768)
        v = -32768;
    return v[DW-1:0];
endfunction

function automatic logic [31:0] strb_merge(input logic [31:0] old_v, input logic [31:0] new_v,
                                           input logic [3:0] strb);
    logic [31:0] m;
    m = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_v & ~m) | (new_v & m);
endfunction

// Random beats of one job and the output beats they should produce.
task automatic plan_job(input int cols, input int cin, input int vbits, input bit max_mode,
                        input int sh, input bit relu);
    logic [PIX_W-1:0] p;
    logic [WGT_W-1:0] w;
    logic [OUT_W-1:0] o;
    longint t;
    longint acc [UNITS];
    pix_q.delete();
    wgt_q.delete();
    exp_q.delete();
    for (int c = 0; c <= cols; c++) begin
        for (int ch = 0; ch <= cin; ch++) begin
            for (int n = 0; n < PIX_N; n++)
                p[n*DW +: DW] = rand_sample(data_lfsr, vbits);
            for (int k = 0; k < TAPS; k++)
                w[k*DW +: DW] = rand_sample(data_lfsr, vbits);
            for (int u = 0; u < UNITS; u++) begin
                t = unit_term(p, w, u, max_mode);
                if (ch == 0 || (max_mode && t > acc[u]))
                    acc[u] = t;
                else if (!max_mode)
                    acc[u] = acc[u] + t;
            end
            pix_q.push_back(p);
            wgt_q.push_back(w);
        end
        for (int u = 0; u < UNITS; u++)
            o[u*DW +: DW] = out_sample(acc[u], sh, relu);
        exp_q.push_back(o);
    end
endtask

`endif

// File: verif/conv_engine_tb.sv
`timescale 1ns/10ps
`default_nettype none

module conv_engine_tb;

    localparam int UNITS = 8;
    localparam int TAPS  = 3;
    localparam int DW    = 16;
    localparam int PIX_N = UNITS + TAPS - 1;
    localparam int PIX_W = PIX_N * DW;
    localparam int WGT_W = TAPS * DW;
    localparam int OUT_W = UNITS * DW;
    localparam logic [31:0] SEED       = 32'h4979b9be;
    localparam logic [31:0] SHAPE_MASK = 32'h03ff_03ff;   // cols_1 and cin_1 fields.
    localparam logic [1:0]  OKAY       = conv_axil_pkg::resp_okay;
    localparam logic [1:0]  SLVERR     = conv_axil_pkg::resp_slverr;
    // Six tests of at most 30 input beats, 6 output beats and 12 register accesses.
    localparam int BEAT_BUDGET = 6 * (6 * 5 + 6 + 12);

    logic aclk, rst_n;
    logic [3:0] awaddr, araddr, wstrb;
    logic [31:0] wdata, rdata;
    logic [1:0] bresp, rresp;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic s_pixels_valid, s_pixels_ready, s_weights_valid, s_weights_ready;
    logic [PIX_W-1:0] s_pixels_data;
    logic [WGT_W-1:0] s_weights_data;
    logic m_valid, m_last, m_ready;
    logic [OUT_W-1:0] m_data;

    logic [PIX_W-1:0] pix_q [$];
    logic [WGT_W-1:0] wgt_q [$];
    logic [OUT_W-1:0] exp_q [$];
    logic [31:0] data_lfsr, gap_lfsr, stall_lfsr;
    int errors;
    int test_num;

    `include "conv_engine_model.svh"

    conv_engine_top #(.CONV_UNITS(UNITS), .KERNEL_H(TAPS)) i_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    initial begin
        #(BEAT_BUDGET * 20 * 10);
        $display("Timeout: the run did not end within %0d cycles", BEAT_BUDGET * 20);
        $display("tests failed");
        $finish;
    end

    // ************************************************************
    // Reporting.
    // ************************************************************
    task automatic report_mismatch(input string sig, input logic [255:0] exp,
                                   input logic [255:0] got);
        errors++;
        $display("Fail at %0d ns: %s expected %0h, got %0h", $time, sig, exp, got);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_num++;
        $display("Test %0d, %s: %0d errors", test_num, name, errors - errs_before);
    endtask

    // ************************************************************
    // AXI4-Lite master.
    // ************************************************************
    task automatic write_expect(input logic [3:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, input logic [1:0] exp_resp);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge aclk); while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge aclk); while (!bvalid);
        if (bresp !== exp_resp)
            report_mismatch("bresp", exp_resp, bresp);
    endtask

    task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp_data,
                               input logic [1:0] exp_resp, input bit check_data);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge aclk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge aclk); while (!rvalid);
        if (rresp !== exp_resp)
            report_mismatch("rresp", exp_resp, rresp);
        if (check_data && rdata !== exp_data)
            report_mismatch("rdata", exp_data, rdata);
    endtask

    // ************************************************************
    // Streams.
    // ************************************************************
    task automatic drive_inputs(input bit gaps, input bit max_mode);
        for (int i = 0; i < pix_q.size(); i++) begin
            if (gaps) begin
                s_pixels_valid  <= 1'b0;
                s_weights_valid <= 1'b0;
                repeat (rand_bits(gap_lfsr, 2)) @(posedge aclk);
            end
            s_pixels_valid  <= 1'b1;
            s_weights_valid <= 1'b1;   // Offered in max mode too.
            s_pixels_data   <= pix_q[i];
            s_weights_data  <= wgt_q[i];
            do begin
                @(posedge aclk);
                if (max_mode && s_weights_ready)
                    report_problem("s_weights_ready is high in max mode");
                if (!max_mode && s_weights_ready !== s_pixels_ready)
                    report_mismatch("s_weights_ready", s_pixels_ready, s_weights_ready);
            end while (!s_pixels_ready);
        end
        s_pixels_valid  <= 1'b0;
        s_weights_valid <= 1'b0;
    endtask

    task automatic collect_outputs(input bit stall);
        int k;
        logic held;
        logic [OUT_W:0] held_beat;
        k = 0;
        held = 1'b0;
        while (k < exp_q.size()) begin
            m_ready <= stall ? (rand_bits(stall_lfsr, 1) != 0) : 1'b1;
            @(posedge aclk);
            if (held && !m_valid)
                report_problem("m_valid dropped while m_ready was low");
            if (held && {m_last, m_data} !== held_beat)
                report_mismatch("m_data held", held_beat, {m_last, m_data});
            held      = m_valid && !m_ready;
            held_beat = {m_last, m_data};
            if (m_valid && m_ready) begin
                if (m_data !== exp_q[k])
                    report_mismatch("m_data", exp_q[k], m_data);
                if (m_last !== (k == exp_q.size() - 1))
                    report_mismatch("m_last", k == exp_q.size() - 1, m_last);
                k++;
            end
        end
        m_ready <= 1'b1;
    endtask

    // ************************************************************
    // Tests.
    // ************************************************************
    task automatic test_registers();
        int errs_before;
        logic [31:0] v;
        logic [31:0] shape;
        logic [31:0] shift;
        errs_before = errors;
        v     = rand_bits(data_lfsr, 32);
        shape = v & SHAPE_MASK;
        write_expect(conv_axil_pkg::reg_shape, v, 4'hf, OKAY);
        read_expect(conv_axil_pkg::reg_shape, shape, OKAY, 1'b1);
        v     = rand_bits(data_lfsr, 32);
        shape = strb_merge(shape, v, 4'b0100) & SHAPE_MASK;   // Only cin_1 low byte.
        write_expect(conv_axil_pkg::reg_shape, v, 4'b0100, OKAY);
        read_expect(conv_axil_pkg::reg_shape, shape, OKAY, 1'b1);
        v     = rand_bits(data_lfsr, 32);
        shift = v & 32'h1f;
        write_expect(conv_axil_pkg::reg_shift, v, 4'hf, OKAY);
        read_expect(conv_axil_pkg::reg_shift, shift, OKAY, 1'b1);
        write_expect(conv_axil_pkg::reg_shift, ~v, 4'b1110, OKAY);
        read_expect(conv_axil_pkg::reg_shift, shift, OKAY, 1'b1);
        read_expect(4'h6, 32'h0, SLVERR, 1'b0);
        write_expect(conv_axil_pkg::reg_status, 32'h1, 4'hf, SLVERR);
        read_expect(conv_axil_pkg::reg_status, 32'h0, OKAY, 1'b1);
        finish_test("register access", errs_before);
    endtask

    task automatic run_job(input string name, input int vbits, input bit max_mode,
                           input int sh, input bit relu, input bit gaps, input bit poke);
        int errs_before;
        int cols;
        int cin;
        errs_before = errors;
        cols = poke ? 5 : rand_bits(data_lfsr, 3) % 6;
        cin  = poke ? 4 : rand_bits(data_lfsr, 3) % 5;
        plan_job(cols, cin, vbits, max_mode, sh, relu);
        write_expect(conv_axil_pkg::reg_shape, (cin << 16) | cols, 4'hf, OKAY);
        write_expect(conv_axil_pkg::reg_shift, sh, 4'hf, OKAY);
        write_expect(conv_axil_pkg::reg_ctrl, {relu, max_mode, 1'b1}, 4'hf, OKAY);
        read_expect(conv_axil_pkg::reg_status, 32'h1, OKAY, 1'b1);
        fork
            drive_inputs(gaps, max_mode);
            collect_outputs(gaps);
            if (poke) begin
                write_expect(conv_axil_pkg::reg_ctrl, 32'h7, 4'hf, OKAY);   // Restart as max.
                write_expect(conv_axil_pkg::reg_shape, 32'h0, 4'hf, OKAY);
                read_expect(conv_axil_pkg::reg_status, 32'h1, OKAY, 1'b1);
            end
        join
        repeat (3) begin
            @(posedge aclk);
            if (m_valid)
                report_problem("output beat after the last beat of the job");
        end
        read_expect(conv_axil_pkg::reg_status, 32'h0, OKAY, 1'b1);
        if (poke) begin
            read_expect(conv_axil_pkg::reg_shape, (cin << 16) | cols, OKAY, 1'b1);
            read_expect(conv_axil_pkg::reg_ctrl, {relu, max_mode, 1'b0}, OKAY, 1'b1);
        end
        finish_test(name, errs_before);
    endtask

    initial begin
        data_lfsr  = SEED;
        gap_lfsr   = ~SEED;
        stall_lfsr = {SEED[15:0], SEED[31:16]};
        errors     = 0;
        test_num   = 0;
        rst_n           <= 1'b0;
        awaddr          <= '0;
        awvalid         <= 1'b0;
        wdata           <= '0;
        wstrb           <= '0;
        wvalid          <= 1'b0;
        bready          <= 1'b1;
        araddr          <= '0;
        arvalid         <= 1'b0;
        rready          <= 1'b1;
        s_pixels_valid  <= 1'b0;
        s_pixels_data   <= '0;
        s_weights_valid <= 1'b0;
        s_weights_data  <= '0;
        m_ready         <= 1'b0;
        repeat (5) @(posedge aclk);
        rst_n <= 1'b1;
        @(posedge aclk);
        if (awready || wready || bvalid || arready || rvalid || s_pixels_ready ||
            s_weights_ready || m_valid)
            report_problem("a ready or valid output is high after reset");
        test_registers();
        run_job("conv mode", 8, 1'b0, 0, 1'b0, 1'b0, 1'b0);
        run_job("shift, ReLU and saturation", 16, 1'b0, 4, 1'b1, 1'b0, 1'b0);
        run_job("max mode", 16, 1'b1, 2, 1'b1, 1'b0, 1'b0);
        run_job("back-pressure and gaps", 12, 1'b0, 3, 1'b0, 1'b1, 1'b0);
        run_job("start while busy", 8, 1'b0, 0, 1'b0, 1'b1, 1'b1);
        $display("%0d tests run, %0d errors", test_num, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+verif
logic/conv_types_pkg.sv
logic/conv_axil_pkg.sv
logic/conv_cfg_regs.sv
logic/conv_tap_mac.sv
logic/conv_result_stage.sv
logic/conv_engine_top.sv
verif/conv_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= conv_engine_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
